// ==== sram_test.f ====
design/sram_test_pkg.sv
design/scan_chain.sv
design/sram_access_ctrl.sv
design/sram_1rw1r_model.sv
design/sram_test_top.sv
testbench/tb_sram_test.sv

// ==== Makefile ====
# Verilator build, run and lint for the SRAM test harness

TOP = tb_sram_test

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sram_test.f design/*.sv testbench/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f sram_test.f

# Pass only when the simulation prints the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module sram_test_top -f sram_test.f

clean:
	rm -rf obj_dir

// ==== testbench/tb_sram_test.sv ====
// Testbench for the SRAM test harness
// Shadow-memory reference, compare process, directed and random accesses

`timescale 1ns/1ps

module tb_sram_test;

   localparam int TIMEOUT_CYCLES = 20000;

   typedef logic [sram_test_pkg::SEL_W-1:0]   sel_t;
   typedef logic [sram_test_pkg::ADDR_W-1:0]  addr_t;
   typedef logic [sram_test_pkg::DATA_W-1:0]  data_t;
   typedef logic [sram_test_pkg::WMASK_W-1:0] mask_t;

   logic                      clk;
   logic                      resetn;
   logic                      scan_en_i;
   logic                      scan_i;
   logic                      scan_o;
   logic                      load_en_i;
   sram_test_pkg::scan_word_u load_data_i;
   logic                      sram_load_i;
   logic                      busy_o;
   sram_test_pkg::scan_word_u word_o;

   // Shadow copies of the four macros
   data_t shadow0 [sram_test_pkg::MACRO_DEPTH[0]];
   data_t shadow1 [sram_test_pkg::MACRO_DEPTH[1]];
   data_t shadow2 [sram_test_pkg::MACRO_DEPTH[2]];
   data_t shadow3 [sram_test_pkg::MACRO_DEPTH[3]];

   sram_test_pkg::sram_res_t exp_q [$];
   sram_test_pkg::sram_res_t last_exp;
   int                       errors;
   int                       issued_cnt;
   int                       checked_cnt;
   int                       cycle_cnt;
   integer                   seed;

   sram_test_top i_sram_test_top (
      .clk         (clk),
      .resetn      (resetn),
      .scan_en_i   (scan_en_i),
      .scan_i      (scan_i),
      .scan_o      (scan_o),
      .load_en_i   (load_en_i),
      .load_data_i (load_data_i),
      .sram_load_i (sram_load_i),
      .busy_o      (busy_o),
      .word_o      (word_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit, about 100 accesses of up to 140 cycles plus margin
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d", errors);
      $display("CHECKS FAILED");
      $finish;
   end

   function automatic int depth_of(sel_t sel);
      case (sel)
         2'd0:    return sram_test_pkg::MACRO_DEPTH[0];
         2'd1:    return sram_test_pkg::MACRO_DEPTH[1];
         2'd2:    return sram_test_pkg::MACRO_DEPTH[2];
         default: return sram_test_pkg::MACRO_DEPTH[3];
      endcase
   endfunction

   // Addresses wrap modulo the macro depth
   function automatic data_t shadow_read(sel_t sel, addr_t addr);
      case (sel)
         2'd0:    return shadow0[int'(addr) % sram_test_pkg::MACRO_DEPTH[0]];
         2'd1:    return shadow1[int'(addr) % sram_test_pkg::MACRO_DEPTH[1]];
         2'd2:    return shadow2[int'(addr) % sram_test_pkg::MACRO_DEPTH[2]];
         default: return shadow3[int'(addr) % sram_test_pkg::MACRO_DEPTH[3]];
      endcase
   endfunction

   function automatic void shadow_write(sel_t sel, addr_t addr, data_t din, mask_t mask);
      data_t word;
      word = shadow_read(sel, addr);
      for (int b = 0; b < sram_test_pkg::WMASK_W; b++) begin
         if (mask[b]) begin
            word[b*sram_test_pkg::BYTE_W +: sram_test_pkg::BYTE_W] =
               din[b*sram_test_pkg::BYTE_W +: sram_test_pkg::BYTE_W];
         end
      end
      case (sel)
         2'd0:    shadow0[int'(addr) % sram_test_pkg::MACRO_DEPTH[0]] = word;
         2'd1:    shadow1[int'(addr) % sram_test_pkg::MACRO_DEPTH[1]] = word;
         2'd2:    shadow2[int'(addr) % sram_test_pkg::MACRO_DEPTH[2]] = word;
         default: shadow3[int'(addr) % sram_test_pkg::MACRO_DEPTH[3]] = word;
      endcase
   endfunction

   // Expected result of one request, shadow updated on a write
   function automatic sram_test_pkg::sram_res_t apply_request(sram_test_pkg::sram_req_t r);
      sram_test_pkg::sram_res_t res;
      res = '0;
      // Both reads see the memory before this access writes it
      if (!r.csb1) begin
         res.dout1 = shadow_read(r.sel, r.addr1);
      end
      if (!r.csb0 && r.web0) begin
         res.dout0 = shadow_read(r.sel, r.addr0);
      end
      if (!r.csb0 && !r.web0) begin
         shadow_write(r.sel, r.addr0, r.din0, r.wmask0);
      end
      return res;
   endfunction

   function automatic sram_test_pkg::sram_req_t make_req(sel_t sel, logic csb0, logic web0,
                                                         mask_t wmask0, addr_t addr0,
                                                         data_t din0, logic csb1,
                                                         addr_t addr1);
      sram_test_pkg::sram_req_t r;
      r.spare  = 1'b0;
      r.sel    = sel;
      r.csb0   = csb0;
      r.web0   = web0;
      r.wmask0 = wmask0;
      r.addr0  = addr0;
      r.din0   = din0;
      r.csb1   = csb1;
      r.addr1  = addr1;
      return r;
   endfunction

   function automatic data_t rand_word();
      return $random(seed);
   endfunction

   function automatic addr_t rand_addr(sel_t sel);
      data_t r;
      r = $random(seed);
      return addr_t'(r % depth_of(sel));
   endfunction

   task automatic check_result(string name, sram_test_pkg::sram_res_t exp,
                               sram_test_pkg::sram_res_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR: %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_word(string name, sram_test_pkg::scan_word_u exp,
                             sram_test_pkg::scan_word_u act);
      if (act !== exp) begin
         errors++;
         $display("ERROR: %s expected %h got %h", name, exp, act);
      end
   endtask

   // Tasks start and end 1 ns after a rising edge
   task automatic load_word(sram_test_pkg::scan_word_u w);
      load_en_i   = 1'b1;
      load_data_i = w;
      @(posedge clk);
      #1;
      load_en_i   = 1'b0;
   endtask

   task automatic start_access(sram_test_pkg::sram_req_t r);
      sram_test_pkg::sram_res_t exp_res;
      exp_res  = apply_request(r);
      last_exp = exp_res;
      exp_q.push_back(exp_res);
      issued_cnt++;
      sram_load_i = 1'b1;
      @(posedge clk);
      #1;
      sram_load_i = 1'b0;
      // Compare process marks the end of the access
      while (checked_cnt != issued_cnt) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic access(sram_test_pkg::sram_req_t r);
      sram_test_pkg::scan_word_u w;
      w.req = r;
      load_word(w);
      start_access(r);
   endtask

   task automatic write_word(sel_t sel, addr_t addr, data_t din, mask_t mask);
      access(make_req(sel, 1'b0, 1'b0, mask, addr, din, 1'b1, '0));
   endtask

   task automatic read_port0(sel_t sel, addr_t addr);
      access(make_req(sel, 1'b0, 1'b1, '0, addr, '0, 1'b1, '0));
   endtask

   task automatic read_port1(sel_t sel, addr_t addr);
      access(make_req(sel, 1'b1, 1'b1, '0, '0, '0, 1'b0, addr));
   endtask

   task automatic read_both(sel_t sel, addr_t addr0, addr_t addr1);
      access(make_req(sel, 1'b0, 1'b1, '0, addr0, '0, 1'b0, addr1));
   endtask

   // MSB first, so bit 63 ends up first in the chain
   task automatic shift_in(sram_test_pkg::scan_word_u w);
      for (int i = sram_test_pkg::SCAN_W - 1; i >= 0; i--) begin
         scan_en_i = 1'b1;
         scan_i    = w[i];
         @(posedge clk);
         #1;
      end
      scan_en_i = 1'b0;
      scan_i    = 1'b0;
   endtask

   task automatic shift_out(output sram_test_pkg::sram_res_t res);
      res = '0;
      for (int i = 0; i < sram_test_pkg::SCAN_W; i++) begin
         res       = {res[sram_test_pkg::SCAN_W-2:0], scan_o};
         scan_en_i = 1'b1;
         scan_i    = 1'b0;
         @(posedge clk);
         #1;
      end
      scan_en_i = 1'b0;
   endtask

   // Checks the word three edges after every accepted pulse
   initial begin : compare_proc
      sram_test_pkg::sram_res_t exp_res;
      forever begin
         @(negedge clk);
         if (resetn && sram_load_i && !busy_o) begin
            @(posedge clk);
            @(negedge clk);
            // Busy from the cycle after the pulse
            if (busy_o !== 1'b1) begin
               errors++;
               $display("ERROR: busy_o expected 1 got %h", busy_o);
            end
            repeat (3) @(posedge clk);
            @(negedge clk);
            if (exp_q.size() == 0) begin
               errors++;
               $display("A result was captured with no expected value queued");
            end else begin
               exp_res = exp_q.pop_front();
               check_result("word_o.res", exp_res, word_o.res);
            end
            if (busy_o !== 1'b0) begin
               errors++;
               $display("ERROR: busy_o expected 0 got %h", busy_o);
            end
            checked_cnt++;
         end
      end
   end

   initial begin
      sram_test_pkg::sram_req_t  r;
      sram_test_pkg::scan_word_u w;
      sram_test_pkg::scan_word_u zero_word;
      sram_test_pkg::sram_res_t  shifted;
      addr_t                     a;
      data_t                     d;
      data_t                     d2;
      sel_t                      s;

      seed        = 32'h27c8_f90d;
      errors      = 0;
      issued_cnt  = 0;
      checked_cnt = 0;
      resetn      = 1'b0;
      scan_en_i   = 1'b0;
      scan_i      = 1'b0;
      load_en_i   = 1'b0;
      load_data_i = '0;
      sram_load_i = 1'b0;
      zero_word   = '0;

      repeat (3) @(posedge clk);
      #1;
      resetn = 1'b1;

      // Reset state
      @(negedge clk);
      check_word("word_o", zero_word, word_o);
      if (busy_o !== 1'b0) begin
         errors++;
         $display("ERROR: busy_o expected 0 got %h", busy_o);
      end
      @(posedge clk);
      #1;

      // Full-mask write then port 0 read, every macro
      for (int i = 0; i < sram_test_pkg::NUM_MACROS; i++) begin
         s = sel_t'(i);
         a = rand_addr(s);
         write_word(s, a, rand_word(), '1);
         read_port0(s, a);
      end

      // Random partial masks over a known base word
      for (int i = 0; i < 24; i++) begin
         s = sel_t'($random(seed));
         a = rand_addr(s);
         write_word(s, a, rand_word(), '1);
         write_word(s, a, rand_word(), mask_t'($random(seed)));
         read_both(s, a, a);
      end

      // Port 1 alone, then against a same-address write
      for (int i = 0; i < sram_test_pkg::NUM_MACROS; i++) begin
         s  = sel_t'(i);
         a  = rand_addr(s);
         d  = rand_word();
         d2 = rand_word();
         write_word(s, a, d, '1);
         read_port1(s, a);
         access(make_req(s, 1'b0, 1'b0, '1, a, d2, 1'b0, a));
         read_port0(s, a);
      end

      // Aliasing above the depth, macro 0 writes 300 and reads 44
      for (int i = 0; i < 3; i++) begin
         s = sel_t'(i);
         write_word(s, addr_t'(depth_of(s) + 44), rand_word(), '1);
         read_both(s, addr_t'(44), addr_t'(44));
      end

      // Serial request and serial unload
      r   = make_req(2'd0, 1'b0, 1'b1, '0, addr_t'(44), '0, 1'b0, addr_t'(300));
      w.req = r;
      shift_in(w);
      check_word("word_o", w, word_o);
      start_access(r);
      shift_out(shifted);
      check_result("scan_o", last_exp, shifted);
      // Same request on the parallel path
      access(r);

      $display("Checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== design/sram_test_top.sv ====
// Top level of the SRAM test harness
// Scan chain, access controller and four dual-port macros of rising depth

`timescale 1ns/1ps

module sram_test_top (
   input  logic                        clk,
   input  logic                        resetn,

   // Serial host access
   input  logic                        scan_en_i,
   input  logic                        scan_i,
   output logic                        scan_o,

   // Parallel host access
   input  logic                        load_en_i,
   input  sram_test_pkg::scan_word_u   load_data_i,

   // Access control
   input  logic                        sram_load_i,
   output logic                        busy_o,

   output sram_test_pkg::scan_word_u   word_o
);

   sram_test_pkg::scan_word_u                     req_word;
   sram_test_pkg::sram_res_t                      result;
   logic                                          capture;

   // Shared macro inputs
   logic [sram_test_pkg::NUM_MACROS-1:0]          csb0;
   logic [sram_test_pkg::NUM_MACROS-1:0]          csb1;
   logic                                          web0;
   logic [sram_test_pkg::WMASK_W-1:0]             wmask0;
   logic [sram_test_pkg::ADDR_W-1:0]              addr0;
   logic [sram_test_pkg::DATA_W-1:0]              din0;
   logic [sram_test_pkg::ADDR_W-1:0]              addr1;

   // Per-macro read data
   logic [sram_test_pkg::NUM_MACROS-1:0][sram_test_pkg::DATA_W-1:0] dout0;
   logic [sram_test_pkg::NUM_MACROS-1:0][sram_test_pkg::DATA_W-1:0] dout1;

   scan_chain i_scan_chain (
      .clk_i       (clk),
      .resetn_i    (resetn),
      .scan_en_i   (scan_en_i),
      .scan_i      (scan_i),
      .scan_o      (scan_o),
      .load_en_i   (load_en_i),
      .load_data_i (load_data_i),
      .capture_i   (capture),
      .result_i    (result),
      .word_o      (req_word)
   );

   sram_access_ctrl i_sram_access_ctrl (
      .clk_i       (clk),
      .resetn_i    (resetn),
      .sram_load_i (sram_load_i),
      .req_i       (req_word),
      .busy_o      (busy_o),
      .csb0_o      (csb0),
      .csb1_o      (csb1),
      .web0_o      (web0),
      .wmask0_o    (wmask0),
      .addr0_o     (addr0),
      .din0_o      (din0),
      .addr1_o     (addr1),
      .dout0_i     (dout0),
      .dout1_i     (dout1),
      .capture_o   (capture),
      .result_o    (result)
   );

   for (genvar i = 0; i < sram_test_pkg::NUM_MACROS; i++) begin : g_macro
      sram_1rw1r_model #(
         .DEPTH (sram_test_pkg::MACRO_DEPTH[i])
      ) i_sram (
         .clk_i    (clk),
         .csb0_i   (csb0[i]),
         .web0_i   (web0),
         .wmask0_i (wmask0),
         .addr0_i  (addr0),
         .din0_i   (din0),
         .dout0_o  (dout0[i]),
         .csb1_i   (csb1[i]),
         .addr1_i  (addr1),
         .dout1_o  (dout1[i])
      );
   end

   assign word_o = req_word;

endmodule

// ==== design/sram_1rw1r_model.sv ====
// Behavioral dual-port SRAM, one read-write and one read-only port
// Byte-masked writes, registered reads, depth set by parameter

`timescale 1ns/1ps

module sram_1rw1r_model #(
   parameter int DEPTH = 256
) (
   input  logic                                 clk_i,

   // Port 0, read-write
   input  logic                                 csb0_i,
   input  logic                                 web0_i,
   input  logic [sram_test_pkg::WMASK_W-1:0]    wmask0_i,
   input  logic [sram_test_pkg::ADDR_W-1:0]     addr0_i,
   input  logic [sram_test_pkg::DATA_W-1:0]     din0_i,
   output logic [sram_test_pkg::DATA_W-1:0]     dout0_o,

   // Port 1, read only
   input  logic                                 csb1_i,
   input  logic [sram_test_pkg::ADDR_W-1:0]     addr1_i,
   output logic [sram_test_pkg::DATA_W-1:0]     dout1_o
);

   localparam int AW = $clog2(DEPTH);

   logic [sram_test_pkg::DATA_W-1:0] mem [DEPTH];
   logic [AW-1:0]                    a0;
   logic [AW-1:0]                    a1;

   // Upper address bits ignored, so addresses wrap at DEPTH
   assign a0 = addr0_i[AW-1:0];
   assign a1 = addr1_i[AW-1:0];

   always_ff @(posedge clk_i) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < sram_test_pkg::WMASK_W; b++) begin
               if (wmask0_i[b]) begin
                  mem[a0][b*sram_test_pkg::BYTE_W +: sram_test_pkg::BYTE_W] <=
                     din0_i[b*sram_test_pkg::BYTE_W +: sram_test_pkg::BYTE_W];
               end
            end
         end else begin
            dout0_o <= mem[a0];
         end
      end
      // Sees the old word when port 0 writes the same address
      if (!csb1_i) begin
         dout1_o <= mem[a1];
      end
   end

endmodule

// ==== design/sram_access_ctrl.sv ====
// Access sequencer for the SRAM test harness
// Latches one request, drives the macro ports and captures the read data

`timescale 1ns/1ps

module sram_access_ctrl (
   input  logic                                        clk_i,
   input  logic                                        resetn_i,

   // Request side
   input  logic                                        sram_load_i,
   input  sram_test_pkg::scan_word_u                   req_i,
   output logic                                        busy_o,

   // Macro ports, chip selects one bit per macro
   output logic [sram_test_pkg::NUM_MACROS-1:0]        csb0_o,
   output logic [sram_test_pkg::NUM_MACROS-1:0]        csb1_o,
   output logic                                        web0_o,
   output logic [sram_test_pkg::WMASK_W-1:0]           wmask0_o,
   output logic [sram_test_pkg::ADDR_W-1:0]            addr0_o,
   output logic [sram_test_pkg::DATA_W-1:0]            din0_o,
   output logic [sram_test_pkg::ADDR_W-1:0]            addr1_o,

   // Read data from every macro
   input  logic [sram_test_pkg::NUM_MACROS-1:0][sram_test_pkg::DATA_W-1:0] dout0_i,
   input  logic [sram_test_pkg::NUM_MACROS-1:0][sram_test_pkg::DATA_W-1:0] dout1_i,

   // Result back to the scan chain
   output logic                                        capture_o,
   output sram_test_pkg::sram_res_t                    result_o
);

   // Idle, then three busy cycles
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ACCESS  = 2'd1,
      ST_READ    = 2'd2,
      ST_CAPTURE = 2'd3
   } state_t;

   state_t                                   state_q;
   sram_test_pkg::sram_req_t                 req_q;
   sram_test_pkg::sram_res_t                 result_q;
   logic [sram_test_pkg::NUM_MACROS-1:0]     sel_onehot;
   logic [sram_test_pkg::NUM_MACROS-1:0]     csb0_q;
   logic [sram_test_pkg::NUM_MACROS-1:0]     csb1_q;
   logic                                     start;
   logic                                     rd0_en;

   assign start = sram_load_i && (state_q == ST_IDLE);

   // Select field to one-hot
   always_comb begin
      sel_onehot = '0;
      sel_onehot[req_i.req.sel] = 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (!resetn_i) begin
         state_q <= ST_IDLE;
         csb0_q  <= '1;
         csb1_q  <= '1;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (sram_load_i) begin
                  state_q <= ST_ACCESS;
                  // Low only on the selected macro and enabled port
                  csb0_q  <= req_i.req.csb0 ? '1 : ~sel_onehot;
                  csb1_q  <= req_i.req.csb1 ? '1 : ~sel_onehot;
               end
            end
            ST_ACCESS: begin
               // Macro samples at the end of this cycle
               state_q <= ST_READ;
               csb0_q  <= '1;
               csb1_q  <= '1;
            end
            ST_READ:    state_q <= ST_CAPTURE;
            default:    state_q <= ST_IDLE;
         endcase
      end
   end

   // Port 0 returns data only on a read
   assign rd0_en = !req_q.csb0 && req_q.web0;

   always_ff @(posedge clk_i) begin
      if (start) begin
         req_q <= req_i.req;
      end
      if (state_q == ST_READ) begin
         result_q.dout0 <= rd0_en ? dout0_i[req_q.sel] : '0;
         result_q.dout1 <= !req_q.csb1 ? dout1_i[req_q.sel] : '0;
      end
   end

   // Shared fields, qualified by the chip selects
   assign web0_o   = req_q.web0;
   assign wmask0_o = req_q.wmask0;
   assign addr0_o  = req_q.addr0;
   assign din0_o   = req_q.din0;
   assign addr1_o  = req_q.addr1;
   assign csb0_o   = csb0_q;
   assign csb1_o   = csb1_q;

   assign busy_o    = (state_q != ST_IDLE);
   assign capture_o = (state_q == ST_CAPTURE);
   assign result_o  = result_q;

   a_no_load_busy : assert property (
      @(posedge clk_i) disable iff (!resetn_i)
      sram_load_i |-> !busy_o
   ) else $error("sram_load_i while an access is in flight, pulse dropped");

   a_csb0_onehot : assert property (
      @(posedge clk_i) disable iff (!resetn_i)
      $onehot0(~csb0_o)
   ) else $error("more than one macro selected on port 0");

   // Word holds the result three cycles after the pulse
   a_capture_latency : assert property (
      @(posedge clk_i) disable iff (!resetn_i)
      start |-> ##3 capture_o
   ) else $error("capture did not follow an accepted load by three cycles");

endmodule

// ==== design/scan_chain.sv ====
// Scan word register of the SRAM test harness
// Serial shift, parallel load and result capture into one 64-bit word

`timescale 1ns/1ps

module scan_chain (
   input  logic                    clk_i,
   input  logic                    resetn_i,

   // Serial access, bit 0 in and bit 63 out
   input  logic                    scan_en_i,
   input  logic                    scan_i,
   output logic                    scan_o,

   // Parallel access
   input  logic                    load_en_i,
   input  sram_test_pkg::scan_word_u load_data_i,

   // Result from the access controller
   input  logic                    capture_i,
   input  sram_test_pkg::sram_res_t  result_i,

   output sram_test_pkg::scan_word_u word_o
);

   sram_test_pkg::scan_word_u word_q;

   // Capture beats load, load beats shift
   always_ff @(posedge clk_i) begin
      if (!resetn_i) begin
         word_q <= '0;
      end else if (capture_i) begin
         word_q.res <= result_i;
      end else if (load_en_i) begin
         word_q <= load_data_i;
      end else if (scan_en_i) begin
         word_q <= {word_q[sram_test_pkg::SCAN_W-2:0], scan_i};
      end
   end

   // MSB leaves first
   assign scan_o = word_q[sram_test_pkg::SCAN_W-1];

   // Same word steers the controller and holds its result
   assign word_o = word_q;

   // Host drives only one of the two load paths in a cycle
   a_shift_load_excl : assert property (
      @(posedge clk_i) disable iff (!resetn_i)
      !(scan_en_i && load_en_i)
   ) else $error("scan_en_i and load_en_i high in the same cycle");

endmodule

// ==== design/sram_test_pkg.sv ====
// Shared widths, macro count and depths for the SRAM test harness
// Request, result and scan word types

package sram_test_pkg;

   // Macro population
   localparam int NUM_MACROS = 4;
   localparam int SEL_W      = 2;

   // Data path widths
   localparam int ADDR_W  = 11;
   localparam int DATA_W  = 32;
   localparam int WMASK_W = 4;
   localparam int BYTE_W  = DATA_W / WMASK_W;

   // Scan word
   localparam int SCAN_W = 64;

   // Words per macro, index is the select value
   localparam int MACRO_DEPTH [NUM_MACROS] = '{256, 512, 1024, 2048};

   // Request view of the scan word, MSB first
   typedef struct packed {
      logic                spare;
      logic [SEL_W-1:0]    sel;
      // Port 0, read-write
      logic                csb0;
      logic                web0;
      logic [WMASK_W-1:0]  wmask0;
      logic [ADDR_W-1:0]   addr0;
      logic [DATA_W-1:0]   din0;
      // Port 1, read only
      logic                csb1;
      logic [ADDR_W-1:0]   addr1;
   } sram_req_t;

   // Result view, both read ports side by side
   typedef struct packed {
      logic [DATA_W-1:0] dout0;
      logic [DATA_W-1:0] dout1;
   } sram_res_t;

   // Same 64 bits, request going in and result coming out
   typedef union packed {
      sram_req_t req;
      sram_res_t res;
   } scan_word_u;

endpackage
